//--- Makefile
TOP = tb_ec_dbl_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f ec_dbl_core.f

obj_dir/V$(TOP): ec_dbl_core.f $(shell cat ec_dbl_core.f)
	verilator --binary --timing --assert --top-module $(TOP) -f ec_dbl_core.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "Simulation ended without a verdict"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- ec_dbl_core.f
ec_field_pkg.sv
ec_sched_pkg.sv
mod_mul.sv
mod_add_sub.sv
ec_point_dbl.sv
ec_dbl_core.sv
ec_dbl_core_sva.sv
tb_ec_dbl_core.sv

//--- ec_dbl_core.sv
// Point doubling core: sequencer with one multiplier, one adder and one subtractor
`default_nettype none

module ec_dbl_core (
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  wire ec_field_pkg::fe_t i_x,
  input  wire ec_field_pkg::fe_t i_y,
  input  wire ec_field_pkg::fe_t i_z,
  input  wire                    i_val,
  output logic                   o_rdy,
  output ec_field_pkg::fe_t      o_x,
  output ec_field_pkg::fe_t      o_y,
  output ec_field_pkg::fe_t      o_z,
  output logic                   o_val,
  input  wire                    i_rdy
);

  // Request and result links, one set per unit
  ec_field_pkg::fe_t mul_a, mul_b, mulr_dat;
  ec_field_pkg::fe_t add_a, add_b, addr_dat;
  ec_field_pkg::fe_t sub_a, sub_b, subr_dat;
  logic [ec_sched_pkg::TAG_W-1:0] mul_tag, mulr_tag, add_tag, addr_tag, sub_tag, subr_tag;
  logic mul_val, mul_rdy, mulr_val, mulr_rdy;
  logic add_val, add_rdy, addr_val, addr_rdy;
  logic sub_val, sub_rdy, subr_val, subr_rdy;

  ec_point_dbl ec_point_dbl_inst (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_x(i_x), .i_y(i_y), .i_z(i_z), .i_val(i_val), .o_rdy(o_rdy),
    .o_x(o_x), .o_y(o_y), .o_z(o_z), .o_val(o_val), .i_rdy(i_rdy),
    .o_mul_a(mul_a), .o_mul_b(mul_b), .o_mul_tag(mul_tag),
    .o_mul_val(mul_val), .i_mul_rdy(mul_rdy),
    .i_mulr_dat(mulr_dat), .i_mulr_tag(mulr_tag),
    .i_mulr_val(mulr_val), .o_mulr_rdy(mulr_rdy),
    .o_add_a(add_a), .o_add_b(add_b), .o_add_tag(add_tag),
    .o_add_val(add_val), .i_add_rdy(add_rdy),
    .i_addr_dat(addr_dat), .i_addr_tag(addr_tag),
    .i_addr_val(addr_val), .o_addr_rdy(addr_rdy),
    .o_sub_a(sub_a), .o_sub_b(sub_b), .o_sub_tag(sub_tag),
    .o_sub_val(sub_val), .i_sub_rdy(sub_rdy),
    .i_subr_dat(subr_dat), .i_subr_tag(subr_tag),
    .i_subr_val(subr_val), .o_subr_rdy(subr_rdy)
  );

  mod_mul mod_mul_inst (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_a(mul_a), .i_b(mul_b), .i_tag(mul_tag), .i_val(mul_val), .o_rdy(mul_rdy),
    .o_dat(mulr_dat), .o_tag(mulr_tag), .o_val(mulr_val), .i_rdy(mulr_rdy)
  );

  mod_add_sub #(.IS_SUB(1'b0)) mod_add_inst (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_a(add_a), .i_b(add_b), .i_tag(add_tag), .i_val(add_val), .o_rdy(add_rdy),
    .o_dat(addr_dat), .o_tag(addr_tag), .o_val(addr_val), .i_rdy(addr_rdy)
  );

  mod_add_sub #(.IS_SUB(1'b1)) mod_sub_inst (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_a(sub_a), .i_b(sub_b), .i_tag(sub_tag), .i_val(sub_val), .o_rdy(sub_rdy),
    .o_dat(subr_dat), .o_tag(subr_tag), .o_val(subr_val), .i_rdy(subr_rdy)
  );

endmodule

`default_nettype wire

//--- ec_dbl_core_sva.sv
// Handshake checks for the point doubling core, bound into ec_dbl_core
`default_nettype none

module ec_dbl_core_sva (
  input wire        i_clk,
  input wire        i_rst,
  input wire        i_out_val,  // Result valid toward the sink
  input wire        i_out_rdy,  // Core ready for a new point
  input wire        i_sink_rdy,
  input wire [47:0] i_out_pt,   // Result x, y, z
  input wire        i_mul_val,
  input wire        i_mul_rdy,
  input wire [35:0] i_mul_req,  // Operands and tag
  input wire        i_add_val,
  input wire        i_add_rdy,
  input wire [35:0] i_add_req,
  input wire        i_sub_val,
  input wire        i_sub_rdy,
  input wire [35:0] i_sub_req
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0; // Failures seen, summed into the final count

  // Result held until the sink takes it
  out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_out_val && !i_sink_rdy |=> i_out_val && $stable(i_out_pt))
    else begin
      fail_cnt++;
      $error("Result dropped or changed while the sink stalled");
    end

  // Never ready for input while a result waits
  rdy_val_excl: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_out_val && i_out_rdy))
    else begin
      fail_cnt++;
      $error("Core ready for a point while a result is valid");
    end

  mul_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_mul_val && !i_mul_rdy |=> i_mul_val && $stable(i_mul_req))
    else begin
      fail_cnt++;
      $error("Multiplier request dropped or changed before acceptance");
    end

  add_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_add_val && !i_add_rdy |=> i_add_val && $stable(i_add_req))
    else begin
      fail_cnt++;
      $error("Adder request dropped or changed before acceptance");
    end

  sub_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_sub_val && !i_sub_rdy |=> i_sub_val && $stable(i_sub_req))
    else begin
      fail_cnt++;
      $error("Subtractor request dropped or changed before acceptance");
    end

endmodule

bind ec_dbl_core ec_dbl_core_sva ec_dbl_core_sva_inst (
  .i_clk(i_clk), .i_rst(i_rst),
  .i_out_val(o_val), .i_out_rdy(o_rdy), .i_sink_rdy(i_rdy), .i_out_pt({o_x, o_y, o_z}),
  .i_mul_val(mul_val), .i_mul_rdy(mul_rdy), .i_mul_req({mul_a, mul_b, mul_tag}),
  .i_add_val(add_val), .i_add_rdy(add_rdy), .i_add_req({add_a, add_b, add_tag}),
  .i_sub_val(sub_val), .i_sub_rdy(sub_rdy), .i_sub_req({sub_a, sub_b, sub_tag})
);

`default_nettype wire

//--- ec_field_pkg.sv
// Prime field definitions shared by the point doubling datapath
`default_nettype none

package ec_field_pkg;

  // Field element width, one machine word
  localparam int FE_W = 16;

  // Largest 16-bit prime
  localparam logic [FE_W-1:0] P_MOD = 16'd65521;

  // Field element, kept below P_MOD by every unit
  typedef logic [FE_W-1:0] fe_t;

endpackage

`default_nettype wire

//--- ec_point_dbl.sv
// Jacobian point doubling sequencer, issues tagged equations as operands become valid
`default_nettype none

module ec_point_dbl (
  input  wire                            i_clk,
  input  wire                            i_rst,
  input  wire ec_field_pkg::fe_t         i_x,
  input  wire ec_field_pkg::fe_t         i_y,
  input  wire ec_field_pkg::fe_t         i_z,
  input  wire                            i_val,
  output logic                           o_rdy,
  output ec_field_pkg::fe_t              o_x,
  output ec_field_pkg::fe_t              o_y,
  output ec_field_pkg::fe_t              o_z,
  output logic                           o_val,
  input  wire                            i_rdy,
  // Multiplier request and result
  output ec_field_pkg::fe_t              o_mul_a,
  output ec_field_pkg::fe_t              o_mul_b,
  output logic [ec_sched_pkg::TAG_W-1:0] o_mul_tag,
  output logic                           o_mul_val,
  input  wire                            i_mul_rdy,
  input  wire ec_field_pkg::fe_t         i_mulr_dat,
  input  wire [ec_sched_pkg::TAG_W-1:0]  i_mulr_tag,
  input  wire                            i_mulr_val,
  output logic                           o_mulr_rdy,
  // Adder request and result
  output ec_field_pkg::fe_t              o_add_a,
  output ec_field_pkg::fe_t              o_add_b,
  output logic [ec_sched_pkg::TAG_W-1:0] o_add_tag,
  output logic                           o_add_val,
  input  wire                            i_add_rdy,
  input  wire ec_field_pkg::fe_t         i_addr_dat,
  input  wire [ec_sched_pkg::TAG_W-1:0]  i_addr_tag,
  input  wire                            i_addr_val,
  output logic                           o_addr_rdy,
  // Subtractor request and result
  output ec_field_pkg::fe_t              o_sub_a,
  output ec_field_pkg::fe_t              o_sub_b,
  output logic [ec_sched_pkg::TAG_W-1:0] o_sub_tag,
  output logic                           o_sub_val,
  input  wire                            i_sub_rdy,
  input  wire ec_field_pkg::fe_t         i_subr_dat,
  input  wire [ec_sched_pkg::TAG_W-1:0]  i_subr_tag,
  input  wire                            i_subr_val,
  output logic                           o_subr_rdy
);

  ec_sched_pkg::seq_state_t state;
  logic [ec_sched_pkg::N_EQ-1:0] issued, eq_val; // Sent to a unit, result stored
  logic [ec_sched_pkg::N_EQ-1:0] dep_ok, elig;
  ec_field_pkg::fe_t x_l, y_l, z_l;              // Latched input point
  ec_field_pkg::fe_t a_r, b_r, c_r, d_r, e_r;    // Intermediates
  ec_field_pkg::fe_t mul_a_n, mul_b_n, add_a_n, add_b_n, sub_a_n, sub_b_n;
  logic [ec_sched_pkg::TAG_W-1:0] mul_tag_n, add_tag_n, sub_tag_n;
  logic mul_go, add_go, sub_go;
  logic in_acc, mul_issue, add_issue, sub_issue;
  logic mulr_take, addr_take, subr_take;

  assign in_acc     = (state == ec_sched_pkg::IDLE) && o_rdy && i_val;
  assign o_mulr_rdy = (state == ec_sched_pkg::RUN); // Results only arrive in RUN
  assign o_addr_rdy = (state == ec_sched_pkg::RUN);
  assign o_subr_rdy = (state == ec_sched_pkg::RUN);
  assign mulr_take  = i_mulr_val && o_mulr_rdy;
  assign addr_take  = i_addr_val && o_addr_rdy;
  assign subr_take  = i_subr_val && o_subr_rdy;
  // Issue when the request slot is free or draining
  assign mul_issue  = o_mulr_rdy && mul_go && (~o_mul_val || i_mul_rdy);
  assign add_issue  = o_addr_rdy && add_go && (~o_add_val || i_add_rdy);
  assign sub_issue  = o_subr_rdy && sub_go && (~o_sub_val || i_sub_rdy);
  assign elig       = dep_ok & ~issued;

  // Dependencies of each equation
  always_comb begin
    dep_ok = '0;
    dep_ok[ec_sched_pkg::EQ_A_SQ]  = 1'b1;
    dep_ok[ec_sched_pkg::EQ_B_XA]  = eq_val[ec_sched_pkg::EQ_A_SQ];
    dep_ok[ec_sched_pkg::EQ_B_X4]  = eq_val[ec_sched_pkg::EQ_B_XA];
    dep_ok[ec_sched_pkg::EQ_C_SQ]  = eq_val[ec_sched_pkg::EQ_A_SQ];
    dep_ok[ec_sched_pkg::EQ_C_X8]  = eq_val[ec_sched_pkg::EQ_C_SQ];
    dep_ok[ec_sched_pkg::EQ_D_SQ]  = 1'b1;
    dep_ok[ec_sched_pkg::EQ_D_X3]  = eq_val[ec_sched_pkg::EQ_D_SQ];
    dep_ok[ec_sched_pkg::EQ_X_SQ]  = eq_val[ec_sched_pkg::EQ_D_X3];
    dep_ok[ec_sched_pkg::EQ_E_DBL] = eq_val[ec_sched_pkg::EQ_B_X4];
    dep_ok[ec_sched_pkg::EQ_X_SUB] = eq_val[ec_sched_pkg::EQ_E_DBL] & eq_val[ec_sched_pkg::EQ_X_SQ];
    dep_ok[ec_sched_pkg::EQ_Y_SUB] = eq_val[ec_sched_pkg::EQ_X_SUB] & eq_val[ec_sched_pkg::EQ_B_X4];
    dep_ok[ec_sched_pkg::EQ_Y_MUL] = eq_val[ec_sched_pkg::EQ_Y_SUB] & eq_val[ec_sched_pkg::EQ_D_X3];
    dep_ok[ec_sched_pkg::EQ_Y_FIN] = eq_val[ec_sched_pkg::EQ_Y_MUL] & eq_val[ec_sched_pkg::EQ_C_X8];
    dep_ok[ec_sched_pkg::EQ_Z_DBL] = 1'b1;
    dep_ok[ec_sched_pkg::EQ_Z_MUL] = eq_val[ec_sched_pkg::EQ_Z_DBL];
  end

  // Multiplier pick, critical path to X3 first, scalings last
  always_comb begin
    mul_go    = 1'b1;
    mul_tag_n = ec_sched_pkg::EQ_A_SQ;
    if (elig[ec_sched_pkg::EQ_A_SQ]) mul_tag_n = ec_sched_pkg::EQ_A_SQ;
    else if (elig[ec_sched_pkg::EQ_B_XA]) mul_tag_n = ec_sched_pkg::EQ_B_XA;
    else if (elig[ec_sched_pkg::EQ_C_SQ]) mul_tag_n = ec_sched_pkg::EQ_C_SQ;
    else if (elig[ec_sched_pkg::EQ_D_SQ]) mul_tag_n = ec_sched_pkg::EQ_D_SQ;
    else if (elig[ec_sched_pkg::EQ_D_X3]) mul_tag_n = ec_sched_pkg::EQ_D_X3;
    else if (elig[ec_sched_pkg::EQ_X_SQ]) mul_tag_n = ec_sched_pkg::EQ_X_SQ;
    else if (elig[ec_sched_pkg::EQ_Y_MUL]) mul_tag_n = ec_sched_pkg::EQ_Y_MUL;
    else if (elig[ec_sched_pkg::EQ_Z_MUL]) mul_tag_n = ec_sched_pkg::EQ_Z_MUL;
    else if (elig[ec_sched_pkg::EQ_B_X4]) mul_tag_n = ec_sched_pkg::EQ_B_X4;
    else if (elig[ec_sched_pkg::EQ_C_X8]) mul_tag_n = ec_sched_pkg::EQ_C_X8;
    else mul_go = 1'b0; // Nothing ready
    {mul_a_n, mul_b_n} = '0;
    case (mul_tag_n)
      ec_sched_pkg::EQ_A_SQ:  {mul_a_n, mul_b_n} = {y_l, y_l};
      ec_sched_pkg::EQ_B_XA:  {mul_a_n, mul_b_n} = {x_l, a_r};
      ec_sched_pkg::EQ_B_X4:  {mul_a_n, mul_b_n} = {b_r, ec_field_pkg::fe_t'(4)};
      ec_sched_pkg::EQ_C_SQ:  {mul_a_n, mul_b_n} = {a_r, a_r};
      ec_sched_pkg::EQ_C_X8:  {mul_a_n, mul_b_n} = {c_r, ec_field_pkg::fe_t'(8)};
      ec_sched_pkg::EQ_D_SQ:  {mul_a_n, mul_b_n} = {x_l, x_l};
      ec_sched_pkg::EQ_D_X3:  {mul_a_n, mul_b_n} = {ec_field_pkg::fe_t'(3), d_r};
      ec_sched_pkg::EQ_X_SQ:  {mul_a_n, mul_b_n} = {d_r, d_r};
      ec_sched_pkg::EQ_Y_MUL: {mul_a_n, mul_b_n} = {d_r, o_y};
      ec_sched_pkg::EQ_Z_MUL: {mul_a_n, mul_b_n} = {o_z, z_l};
      default: ;
    endcase
  end

  // Adder and subtractor picks
  always_comb begin
    add_go    = 1'b1;
    add_tag_n = ec_sched_pkg::EQ_E_DBL;
    add_a_n   = b_r; // E = B + B
    if (!elig[ec_sched_pkg::EQ_E_DBL]) begin
      add_tag_n = ec_sched_pkg::EQ_Z_DBL;
      add_a_n   = y_l; // Z3 = y + y
      add_go    = elig[ec_sched_pkg::EQ_Z_DBL];
    end
    add_b_n = add_a_n; // Both adds are doublings
    sub_go    = 1'b1;
    sub_tag_n = ec_sched_pkg::EQ_X_SUB;
    if (elig[ec_sched_pkg::EQ_X_SUB]) sub_tag_n = ec_sched_pkg::EQ_X_SUB;
    else if (elig[ec_sched_pkg::EQ_Y_SUB]) sub_tag_n = ec_sched_pkg::EQ_Y_SUB;
    else if (elig[ec_sched_pkg::EQ_Y_FIN]) sub_tag_n = ec_sched_pkg::EQ_Y_FIN;
    else sub_go = 1'b0;
    case (sub_tag_n)
      ec_sched_pkg::EQ_Y_SUB: {sub_a_n, sub_b_n} = {b_r, o_x};
      ec_sched_pkg::EQ_Y_FIN: {sub_a_n, sub_b_n} = {o_y, c_r};
      default:                {sub_a_n, sub_b_n} = {o_x, e_r}; // X3 - E
    endcase
  end

  // Control: state, masks and request valids
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ec_sched_pkg::IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      issued    <= '0;
      eq_val    <= '0;
      o_mul_val <= 1'b0;
      o_add_val <= 1'b0;
      o_sub_val <= 1'b0;
    end else begin
      if (i_mul_rdy) o_mul_val <= 1'b0;
      if (i_add_rdy) o_add_val <= 1'b0;
      if (i_sub_rdy) o_sub_val <= 1'b0;
      if (mul_issue) begin
        o_mul_val         <= 1'b1;
        issued[mul_tag_n] <= 1'b1;
      end
      if (add_issue) begin
        o_add_val         <= 1'b1;
        issued[add_tag_n] <= 1'b1;
      end
      if (sub_issue) begin
        o_sub_val         <= 1'b1;
        issued[sub_tag_n] <= 1'b1;
      end
      if (mulr_take) eq_val[i_mulr_tag] <= 1'b1;
      if (addr_take) eq_val[i_addr_tag] <= 1'b1;
      if (subr_take) eq_val[i_subr_tag] <= 1'b1;
      case (state)
        ec_sched_pkg::IDLE: begin
          if (in_acc) begin
            o_rdy  <= 1'b0;
            issued <= '0;
            eq_val <= '0;
            if (i_z == '0) begin // Point at infinity, pass straight through
              state <= ec_sched_pkg::DONE;
              o_val <= 1'b1;
            end else begin
              state <= ec_sched_pkg::RUN;
            end
          end else begin
            o_rdy <= 1'b1;
          end
        end
        ec_sched_pkg::RUN: begin
          if (&eq_val) begin // Last result landed last cycle
            state <= ec_sched_pkg::DONE;
            o_val <= 1'b1;
          end
        end
        default: begin
          if (o_val && i_rdy) begin
            state <= ec_sched_pkg::IDLE;
            o_val <= 1'b0;
          end
        end
      endcase
    end
  end

  // Datapath: latched point, requests and result write-back by tag
  always_ff @(posedge i_clk) begin
    if (in_acc) begin
      x_l <= i_x;
      y_l <= i_y;
      z_l <= i_z;
      o_x <= i_x; // Already the answer when z is zero
      o_y <= i_y;
      o_z <= i_z;
    end
    if (mul_issue) begin
      o_mul_a   <= mul_a_n;
      o_mul_b   <= mul_b_n;
      o_mul_tag <= mul_tag_n;
    end
    if (add_issue) begin
      o_add_a   <= add_a_n;
      o_add_b   <= add_b_n;
      o_add_tag <= add_tag_n;
    end
    if (sub_issue) begin
      o_sub_a   <= sub_a_n;
      o_sub_b   <= sub_b_n;
      o_sub_tag <= sub_tag_n;
    end
    if (mulr_take) begin
      case (i_mulr_tag)
        ec_sched_pkg::EQ_A_SQ:                        a_r <= i_mulr_dat;
        ec_sched_pkg::EQ_B_XA, ec_sched_pkg::EQ_B_X4: b_r <= i_mulr_dat;
        ec_sched_pkg::EQ_C_SQ, ec_sched_pkg::EQ_C_X8: c_r <= i_mulr_dat;
        ec_sched_pkg::EQ_D_SQ, ec_sched_pkg::EQ_D_X3: d_r <= i_mulr_dat;
        ec_sched_pkg::EQ_X_SQ:                        o_x <= i_mulr_dat;
        ec_sched_pkg::EQ_Y_MUL:                       o_y <= i_mulr_dat;
        ec_sched_pkg::EQ_Z_MUL:                       o_z <= i_mulr_dat;
        default: ;
      endcase
    end
    if (addr_take) begin
      if (i_addr_tag == ec_sched_pkg::EQ_E_DBL) e_r <= i_addr_dat;
      else o_z <= i_addr_dat; // 2y
    end
    if (subr_take) begin
      if (i_subr_tag == ec_sched_pkg::EQ_X_SUB) o_x <= i_subr_dat;
      else o_y <= i_subr_dat; // B - X3, then minus C
    end
  end

endmodule

`default_nettype wire

//--- ec_sched_pkg.sv
// Doubling schedule definitions: equation tags and sequencer states
`default_nettype none

package ec_sched_pkg;

  localparam int TAG_W = 4;  // Tag carried with every unit request
  localparam int N_EQ  = 15; // Equations in one doubling

  // Equation numbers, dependencies in brackets
  localparam logic [TAG_W-1:0] EQ_A_SQ  = 4'd0;  // A = y^2
  localparam logic [TAG_W-1:0] EQ_B_XA  = 4'd1;  // B = x*A [0]
  localparam logic [TAG_W-1:0] EQ_B_X4  = 4'd2;  // B = 4*B [1]
  localparam logic [TAG_W-1:0] EQ_C_SQ  = 4'd3;  // C = A^2 [0]
  localparam logic [TAG_W-1:0] EQ_C_X8  = 4'd4;  // C = 8*C [3]
  localparam logic [TAG_W-1:0] EQ_D_SQ  = 4'd5;  // D = x^2
  localparam logic [TAG_W-1:0] EQ_D_X3  = 4'd6;  // D = 3*D [5]
  localparam logic [TAG_W-1:0] EQ_X_SQ  = 4'd7;  // X3 = D^2 [6]
  localparam logic [TAG_W-1:0] EQ_E_DBL = 4'd8;  // E = 2*B [2]
  localparam logic [TAG_W-1:0] EQ_X_SUB = 4'd9;  // X3 = X3 - E [8, 7]
  localparam logic [TAG_W-1:0] EQ_Y_SUB = 4'd10; // Y3 = B - X3 [9, 2]
  localparam logic [TAG_W-1:0] EQ_Y_MUL = 4'd11; // Y3 = D*Y3 [10, 6]
  localparam logic [TAG_W-1:0] EQ_Y_FIN = 4'd12; // Y3 = Y3 - C [11, 4]
  localparam logic [TAG_W-1:0] EQ_Z_DBL = 4'd13; // Z3 = 2*y
  localparam logic [TAG_W-1:0] EQ_Z_MUL = 4'd14; // Z3 = Z3*z [13]

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE, // Waiting for a point
    RUN,  // Equations in flight
    DONE  // Result held for the sink
  } seq_state_t;

endpackage

`default_nettype wire

//--- mod_add_sub.sv
// Registered modular adder or subtractor with tag pass-through
`default_nettype none

module mod_add_sub #(
  parameter bit IS_SUB = 1'b0 // 1 gives a - b, 0 gives a + b
) (
  input  wire                            i_clk,
  input  wire                            i_rst,
  input  wire ec_field_pkg::fe_t         i_a,
  input  wire ec_field_pkg::fe_t         i_b,
  input  wire [ec_sched_pkg::TAG_W-1:0]  i_tag,
  input  wire                            i_val,
  output logic                           o_rdy,
  output ec_field_pkg::fe_t              o_dat,
  output logic [ec_sched_pkg::TAG_W-1:0] o_tag,
  output logic                           o_val,
  input  wire                            i_rdy
);

  logic [ec_field_pkg::FE_W:0] p_w;
  logic [ec_field_pkg::FE_W:0] res_w; // Result with carry or borrow bit

  assign p_w   = {1'b0, ec_field_pkg::P_MOD};
  assign o_rdy = ~o_val | i_rdy; // Empty, or emptying this cycle

  always_comb begin
    if (IS_SUB) begin
      res_w = {1'b0, i_a} - {1'b0, i_b};
      if (i_a < i_b) res_w = res_w + p_w; // Borrow, wrap back above zero
    end else begin
      res_w = {1'b0, i_a} + {1'b0, i_b};
      if (res_w >= p_w) res_w = res_w - p_w; // At most one fold needed
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) o_val <= 1'b0;
    else if (i_val && o_rdy) o_val <= 1'b1;
    else if (i_rdy) o_val <= 1'b0;
  end

  // Output register
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      o_dat <= res_w[ec_field_pkg::FE_W-1:0];
      o_tag <= i_tag;
    end
  end

endmodule

`default_nettype wire

//--- mod_mul.sv
// Bit-serial modular multiplier with tag pass-through, one product at a time
`default_nettype none

module mod_mul (
  input  wire                            i_clk,
  input  wire                            i_rst,
  input  wire ec_field_pkg::fe_t         i_a,
  input  wire ec_field_pkg::fe_t         i_b,
  input  wire [ec_sched_pkg::TAG_W-1:0]  i_tag,
  input  wire                            i_val,
  output logic                           o_rdy,
  output ec_field_pkg::fe_t              o_dat,
  output logic [ec_sched_pkg::TAG_W-1:0] o_tag,
  output logic                           o_val,
  input  wire                            i_rdy
);

  logic [ec_field_pkg::FE_W:0] p_w;   // Modulus with a carry bit
  logic [ec_field_pkg::FE_W:0] dbl_w; // 2*acc reduced
  logic [ec_field_pkg::FE_W:0] sum_w; // Next accumulator value
  ec_field_pkg::fe_t a_r, b_r, acc;
  logic [$clog2(ec_field_pkg::FE_W+1)-1:0] cnt; // Iteration count
  logic busy;
  logic last;

  assign p_w   = {1'b0, ec_field_pkg::P_MOD};
  assign last  = (cnt == ec_field_pkg::FE_W); // All bits of b consumed
  assign o_rdy = ~busy & (~o_val | i_rdy);    // Held result blocks a new product
  assign o_dat = acc;                         // Accumulator frozen once done

  // One step of double and add, each followed by one fold
  always_comb begin
    dbl_w = {acc, 1'b0};
    if (dbl_w >= p_w) dbl_w = dbl_w - p_w;
    if (b_r[ec_field_pkg::FE_W-1]) sum_w = dbl_w + {1'b0, a_r}; // Top bit of b set
    else sum_w = dbl_w;
    if (sum_w >= p_w) sum_w = sum_w - p_w;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      o_val <= 1'b0;
      cnt   <= '0;
    end else begin
      if (o_val && i_rdy) o_val <= 1'b0; // Result drained
      if (i_val && o_rdy) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (last) begin // Extra cycle hands acc to the output
          busy  <= 1'b0;
          o_val <= 1'b1;
        end
      end
    end
  end

  // Operands and accumulator
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      a_r   <= i_a;
      b_r   <= i_b;
      o_tag <= i_tag;
      acc   <= '0;
    end else if (busy && !last) begin
      acc <= sum_w[ec_field_pkg::FE_W-1:0];
      b_r <= b_r << 1; // Next lower bit moves to the top
    end
  end

endmodule

`default_nettype wire

//--- tb_ec_dbl_core.sv
// Testbench for the point doubling core with random and edge points, stalls, reset and a reference check
`default_nettype none

module tb_ec_dbl_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam longint P_FIELD = 65521; // Field prime
  localparam int N_RAND  = 20;
  localparam int N_PULSE = 12;
  localparam int N_PTS   = N_RAND + 2 + 6 + N_PULSE + 2 + 2; // Plus z zero, edges, pair, reset
  localparam int LIMIT   = N_PTS * 200 + 1000;

  logic i_clk, i_rst, i_val, o_rdy, o_val;
  logic i_rdy = 1'b1;
  logic [15:0] i_x, i_y, i_z, o_x, o_y, o_z;
  logic [47:0] pt_q[$];   // Accepted points still owed a result
  string name_q[$];       // Test name of each queued point
  logic [47:0] exp_pt, in_pt;
  string nm;
  logic rdy_rand;         // Random low pulses on i_rdy when set
  int errors = 0;
  int n_sent = 0;
  int n_recv = 0;
  int cycles = 0;
  int idx;

  ec_dbl_core ec_dbl_core_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_x(i_x), .i_y(i_y), .i_z(i_z), .i_val(i_val),
    .o_rdy(o_rdy), .o_x(o_x), .o_y(o_y), .o_z(o_z), .o_val(o_val), .i_rdy(i_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // Jacobian doubling with a = 0 worked equation by equation mod p
  function automatic logic [47:0] ref_dbl(input logic [15:0] x, input logic [15:0] y,
                                          input logic [15:0] z);
    longint xl, yl, zl, a, b, c, d, e, x3, y3, z3;
    xl = longint'(x);
    yl = longint'(y);
    zl = longint'(z);
    if (z == 16'd0) return {x, y, z}; // Point at infinity
    a  = (yl * yl) % P_FIELD;
    b  = (4 * ((xl * a) % P_FIELD)) % P_FIELD;
    c  = (8 * ((a * a) % P_FIELD)) % P_FIELD;
    d  = (3 * ((xl * xl) % P_FIELD)) % P_FIELD;
    e  = (2 * b) % P_FIELD;
    x3 = ((d * d) % P_FIELD - e + P_FIELD) % P_FIELD;
    y3 = (b - x3 + P_FIELD) % P_FIELD;
    y3 = (d * y3) % P_FIELD;
    y3 = (y3 - c + P_FIELD) % P_FIELD;
    z3 = (((2 * yl) % P_FIELD) * zl) % P_FIELD;
    return {x3[15:0], y3[15:0], z3[15:0]};
  endfunction

  function automatic logic [15:0] rand_fe();
    return 16'($urandom % 65521);
  endfunction

  function automatic logic [15:0] rand_nz();
    return 16'(1 + $urandom % 65520); // Never the point at infinity
  endfunction

  task automatic send_point(input logic [15:0] x, input logic [15:0] y, input logic [15:0] z,
                            input string tname);
    @(posedge i_clk);
    i_x   <= x;
    i_y   <= y;
    i_z   <= z;
    i_val <= 1'b1;
    @(negedge i_clk);
    while (!o_rdy) @(negedge i_clk); // Transfer on the next rising edge
    assert (n_recv == n_sent) else begin
      errors++;
      $display("Point of test %s accepted before the earlier result was taken", tname);
    end
    pt_q.push_back({x, y, z});
    name_q.push_back(tname);
    n_sent++;
    @(posedge i_clk);
    i_val <= 1'b0;
  endtask

  task automatic wait_drained();
    while (n_recv != n_sent) @(negedge i_clk);
    @(posedge i_clk); // Last transfer completes here
  endtask

  task automatic report_and_finish(input bit timed_out);
    int total;
    total = errors + ec_dbl_core_inst.ec_dbl_core_sva_inst.fail_cnt + int'(timed_out);
    $display("Results checked: %0d, check errors: %0d, assertion failures: %0d", n_recv,
             errors, ec_dbl_core_inst.ec_dbl_core_sva_inst.fail_cnt);
    if (total == 0) $display("NO ERRORS");
    else $display("ERRORS FOUND");
    $finish;
  endtask

  // Sink side stalls
  always @(posedge i_clk) begin
    if (rdy_rand) i_rdy <= (($urandom % 4) != 0); // About one cycle in four low
    else i_rdy <= 1'b1;
  end

  // Compare each transferred result against the oldest queued point
  always @(negedge i_clk) begin
    if (!i_rst && o_val && i_rdy) begin
      assert (pt_q.size() > 0) else begin
        errors++;
        $display("A result came out with no point waiting for it");
      end
      if (pt_q.size() > 0) begin
        in_pt  = pt_q.pop_front();
        nm     = name_q.pop_front();
        exp_pt = ref_dbl(in_pt[47:32], in_pt[31:16], in_pt[15:0]);
        assert ({o_x, o_y, o_z} == exp_pt) else begin
          errors++;
          $display("FAILED %s: expected %h %h %h actual %h %h %h", nm, exp_pt[47:32],
                   exp_pt[31:16], exp_pt[15:0], o_x, o_y, o_z);
        end
        n_recv++;
      end
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", LIMIT);
      report_and_finish(1'b1);
    end
  end

  initial begin
    void'($urandom(32'h513a)); // Seed the generator once
    i_rst    = 1'b1;
    i_val    = 1'b0;
    i_x      = '0;
    i_y      = '0;
    i_z      = '0;
    rdy_rand = 1'b0;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    for (idx = 0; idx < N_RAND; idx++) send_point(rand_fe(), rand_fe(), rand_nz(), "random");
    send_point(rand_fe(), rand_fe(), 16'd0, "z_zero");
    send_point(16'd65520, 16'd65520, 16'd0, "z_zero_max");
    // Operands that hit the adder and subtractor corrections
    send_point(rand_fe(), 16'd0, rand_nz(), "y_zero");
    send_point(16'd0, rand_fe(), rand_nz(), "x_zero");
    send_point(16'd65520, 16'd65520, 16'd65520, "all_p_minus_1");
    send_point(16'd65520, 16'd1, 16'd1, "x_p_minus_1");
    send_point(16'd1, 16'd65520, 16'd65520, "y_p_minus_1");
    send_point(16'd0, 16'd0, 16'd1, "x_y_zero");
    wait_drained();
    rdy_rand <= 1'b1;
    for (idx = 0; idx < N_PULSE; idx++) send_point(rand_fe(), rand_fe(), rand_nz(), "rdy_pulse");
    wait_drained();
    rdy_rand <= 1'b0;
    send_point(rand_fe(), rand_fe(), rand_nz(), "back_to_back"); // Second waits for the first
    send_point(rand_fe(), rand_fe(), rand_nz(), "back_to_back");
    wait_drained();
    send_point(rand_fe(), rand_fe(), rand_nz(), "reset_abort");
    repeat (40) @(posedge i_clk); // Multiplier busy by now
    i_rst <= 1'b1;
    pt_q.delete(pt_q.size() - 1); // Aborted point owes no result
    name_q.delete(name_q.size() - 1);
    n_sent--;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    send_point(rand_fe(), rand_fe(), rand_nz(), "after_reset");
    wait_drained();
    report_and_finish(1'b0);
  end

endmodule

`default_nettype wire
